/* rtl/imuldiv_pkg.sv */
/*
 * shared types for the iterative multiply/divide unit
 * request opcodes and control FSM states
 */

package imuldiv_pkg;

  // ------------------------------
  // request opcodes
  // ------------------------------

  // signed ops treat both operands as two's complement
  // a divide returns {remainder, quotient}
  typedef enum logic [1:0] {
    // signed multiply, full product
    op_mul  = 2'd0,
    // unsigned multiply, full product
    op_mulu = 2'd1,
    // signed divide
    op_div  = 2'd2,
    // unsigned divide
    op_divu = 2'd3
  } imuldiv_op_e;

  // ------------------------------
  // control FSM states
  // ------------------------------

  typedef enum logic [1:0] {
    // waiting for a request, req_rdy high
    st_idle = 2'd0,
    // one shift step per cycle
    st_calc = 2'd1,
    // sign correction into the result register
    st_fix  = 2'd2,
    // result held until the response is taken
    st_done = 2'd3
  } imuldiv_state_e;

endpackage

/* rtl/imuldiv_opnd_if.sv */
/*
 * operand bundle between the sign unit and the two unsigned cores
 * magnitudes go down, raw unsigned results come back
 */

`timescale 1ns/10ps

interface imuldiv_opnd_if #(
  parameter int data_width = 32
);

  // operand magnitudes, already made positive for signed ops
  logic [data_width-1:0]   mag_a;
  logic [data_width-1:0]   mag_b;

  // raw multiplier output
  logic [2*data_width-1:0] prod;

  // raw divider outputs
  logic [data_width-1:0]   quot;
  logic [data_width-1:0]   rem;

  // sign unit side
  modport sign (output mag_a, output mag_b, input prod, input quot, input rem);

  // core side, mul drives prod, div drives quot and rem
  modport core (input mag_a, input mag_b, output prod, output quot, output rem);

endinterface

/* rtl/imuldiv_ctrl.sv */
/*
 * control FSM for the iterative multiply/divide unit
 * iteration counter, valid/ready handshake and datapath strobes
 */

`timescale 1ns/10ps

module imuldiv_ctrl
  import imuldiv_pkg::*;
#(
  parameter int data_width = 32
) (
  input  logic clk,
  input  logic reset,

  // request handshake
  input  logic req_val,
  output logic req_rdy,

  // response handshake
  output logic resp_val,
  input  logic resp_rdy,

  // datapath strobes
  output logic load,
  output logic step,
  output logic fix
);

  // enough bits to count data_width-1 down to zero
  localparam int cnt_width = (data_width > 1) ? $clog2(data_width) : 1;

  imuldiv_state_e       state;
  logic [cnt_width-1:0] count;

  // ------------------------------
  // output decode
  // ------------------------------

  assign req_rdy  = (state == st_idle);
  assign resp_val = (state == st_done);
  // load marks the accepting edge itself
  assign load     = req_rdy && req_val;
  assign step     = (state == st_calc);
  assign fix      = (state == st_fix);

  // ------------------------------
  // state and counter
  // ------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
      count <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (load) begin
            state <= st_calc;
            // data_width calc cycles, counting down to zero
            count <= cnt_width'(data_width - 1);
          end
        end
        st_calc: begin
          if (count == '0) begin
            state <= st_fix;
          end else begin
            count <= count - 1'b1;
          end
        end
        // single cycle for the sign fix
        st_fix: begin
          state <= st_done;
        end
        st_done: begin
          // hold under back-pressure
          if (resp_rdy) begin
            state <= st_idle;
          end
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

endmodule

/* rtl/imuldiv_sign.sv */
/*
 * sign unit for the multiply/divide unit
 * operand magnitudes, sign capture, final sign fix and result register
 */

`timescale 1ns/10ps

module imuldiv_sign
  import imuldiv_pkg::*;
#(
  parameter int data_width = 32
) (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    load,
  input  logic                    fix,
  input  imuldiv_op_e             req_op,
  input  logic [data_width-1:0]   req_a,
  input  logic [data_width-1:0]   req_b,
  imuldiv_opnd_if.sign            opnd,
  output logic [2*data_width-1:0] result
);

  logic        is_signed;
  logic        neg_a;
  logic        neg_b;

  // captured at load
  imuldiv_op_e op_q;
  logic        neg_a_q;
  logic        neg_b_q;
  logic        div_zero_q;

  // sign corrected results
  logic [2*data_width-1:0] prod_fix;
  logic [data_width-1:0]   quot_fix;
  logic [data_width-1:0]   rem_fix;

  // ------------------------------
  // magnitudes
  // ------------------------------

  assign is_signed = (req_op == op_mul) || (req_op == op_div);
  // msb only counts as a sign on signed ops
  assign neg_a     = is_signed && req_a[data_width-1];
  assign neg_b     = is_signed && req_b[data_width-1];

  assign opnd.mag_a = neg_a ? -req_a : req_a;
  assign opnd.mag_b = neg_b ? -req_b : req_b;

  always_ff @(posedge clk) begin
    if (reset) begin
      op_q       <= op_mul;
      neg_a_q    <= 1'b0;
      neg_b_q    <= 1'b0;
      div_zero_q <= 1'b0;
    end else if (load) begin
      op_q       <= req_op;
      neg_a_q    <= neg_a;
      neg_b_q    <= neg_b;
      div_zero_q <= (req_b == '0);
    end
  end

  // ------------------------------
  // sign fix
  // ------------------------------

  always_comb begin
    // product negative when exactly one operand was
    prod_fix = (neg_a_q ^ neg_b_q) ? -opnd.prod : opnd.prod;
    // divide by zero keeps the all-ones quotient
    quot_fix = ((neg_a_q ^ neg_b_q) && !div_zero_q) ? -opnd.quot : opnd.quot;
    // remainder follows the dividend
    rem_fix  = neg_a_q ? -opnd.rem : opnd.rem;
  end

  always_ff @(posedge clk) begin
    if (fix) begin
      case (op_q)
        op_mul, op_mulu: result <= prod_fix;
        default:         result <= {rem_fix, quot_fix};
      endcase
    end
  end

endmodule

/* rtl/imuldiv_mul_dpath.sv */
/*
 * unsigned shift-add multiplier core
 * one partial product per step, full double width product
 */

`timescale 1ns/10ps

module imuldiv_mul_dpath #(
  parameter int data_width = 32
) (
  input  logic         clk,
  input  logic         reset,
  input  logic         load,
  input  logic         step,
  imuldiv_opnd_if.core opnd
);

  // multiplicand widened so it can shift left over the full product
  logic [2*data_width-1:0] mcand;
  // multiplier, consumed from the low bit
  logic [data_width-1:0]   mplier;
  logic [2*data_width-1:0] prod_reg;

  // ------------------------------
  // operand shifters
  // ------------------------------

  always_ff @(posedge clk) begin
    if (load) begin
      mcand  <= {{data_width{1'b0}}, opnd.mag_a};
      mplier <= opnd.mag_b;
    end else if (step) begin
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
    end
  end

  // accumulate when the current multiplier bit is set
  always_ff @(posedge clk) begin
    if (reset || load) begin
      prod_reg <= '0;
    end else if (step && mplier[0]) begin
      prod_reg <= prod_reg + mcand;
    end
  end

  assign opnd.prod = prod_reg;

endmodule

/* rtl/imuldiv_div_dpath.sv */
/*
 * unsigned restoring divider core
 * one quotient bit per step, msb first
 */

`timescale 1ns/10ps

module imuldiv_div_dpath #(
  parameter int data_width = 32
) (
  input  logic         clk,
  input  logic         reset,
  input  logic         load,
  input  logic         step,
  imuldiv_opnd_if.core opnd
);

  logic [data_width-1:0] dvsr;
  // partial remainder
  logic [data_width-1:0] rem_reg;
  // dividend shifts out the top while quotient bits enter at the bottom
  logic [data_width-1:0] quot_reg;

  // remainder with the next dividend bit appended
  logic [data_width:0]   rem_shift;
  // trial subtraction, msb set means it went negative
  logic [data_width:0]   diff;
  logic                  fits;

  // ------------------------------
  // trial subtract
  // ------------------------------

  assign rem_shift = {rem_reg, quot_reg[data_width-1]};
  assign diff      = rem_shift - {1'b0, dvsr};
  assign fits      = !diff[data_width];

  always_ff @(posedge clk) begin
    if (load) begin
      dvsr <= opnd.mag_b;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      rem_reg  <= '0;
      quot_reg <= '0;
    end else if (load) begin
      rem_reg  <= '0;
      quot_reg <= opnd.mag_a;
    end else if (step) begin
      // restore by keeping the shifted value when the subtract fails
      rem_reg  <= fits ? diff[data_width-1:0] : rem_shift[data_width-1:0];
      quot_reg <= {quot_reg[data_width-2:0], fits};
    end
  end

  // zero divisor always fits, giving all ones and rem = dividend
  assign opnd.quot = quot_reg;
  assign opnd.rem  = rem_reg;

endmodule

/* rtl/imuldiv_top.sv */
/*
 * top level of the iterative multiply/divide unit
 * control FSM, sign unit and the two unsigned cores
 */

`timescale 1ns/10ps

module imuldiv_top
  import imuldiv_pkg::*;
#(
  parameter int data_width = 32
) (
  input  logic                    clk,
  input  logic                    reset,

  // request
  input  logic                    req_val,
  output logic                    req_rdy,
  input  imuldiv_op_e             req_op,
  input  logic [data_width-1:0]   req_a,
  input  logic [data_width-1:0]   req_b,

  // response, {rem, quot} for divides
  output logic                    resp_val,
  input  logic                    resp_rdy,
  output logic [2*data_width-1:0] resp_result
);

  // datapath strobes from the FSM
  logic load;
  logic step;
  logic fix;

  imuldiv_opnd_if #(.data_width(data_width)) opnd_i ();

  // ------------------------------
  // control
  // ------------------------------

  imuldiv_ctrl #(.data_width(data_width)) ctrl_i (
    .clk      (clk),
    .reset    (reset),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy),
    .load     (load),
    .step     (step),
    .fix      (fix)
  );

  // ------------------------------
  // datapath
  // ------------------------------

  imuldiv_sign #(.data_width(data_width)) sign_i (
    .clk    (clk),
    .reset  (reset),
    .load   (load),
    .fix    (fix),
    .req_op (req_op),
    .req_a  (req_a),
    .req_b  (req_b),
    .opnd   (opnd_i.sign),
    .result (resp_result)
  );

  imuldiv_mul_dpath #(.data_width(data_width)) mul_i (
    .clk   (clk),
    .reset (reset),
    .load  (load),
    .step  (step),
    .opnd  (opnd_i.core)
  );

  imuldiv_div_dpath #(.data_width(data_width)) div_i (
    .clk   (clk),
    .reset (reset),
    .load  (load),
    .step  (step),
    .opnd  (opnd_i.core)
  );

endmodule

/* testbench/imuldiv_checker.sv */
/*
 * concurrent handshake and timing assertions for the multiply/divide unit
 * bound into imuldiv_top and counting failed assertions
 */

`timescale 1ns/10ps

module imuldiv_checker #(
  parameter int data_width = 32
) (
  input logic                    clk,
  input logic                    reset,
  input logic                    req_val,
  input logic                    req_rdy,
  input logic                    resp_val,
  input logic                    resp_rdy,
  input logic [2*data_width-1:0] resp_result,
  input logic                    load,
  input logic                    step,
  input logic                    fix
);

  // number of failed assertions so far
  int failures = 0;

  // idle and done never overlap
  a_rdy_val_excl: assert property (@(posedge clk) disable iff (reset)
    !(req_rdy && resp_val))
    else begin
      failures++;
      $error("req_rdy and resp_val high in the same cycle");
    end

  // a held response must not change
  a_result_stable: assert property (@(posedge clk) disable iff (reset)
    (resp_val && !resp_rdy) |=> $stable(resp_result))
    else begin
      failures++;
      $error("resp_result changed under back-pressure");
    end

  // data_width calc cycles and one fix cycle before done
  a_latency: assert property (@(posedge clk) disable iff (reset)
    (req_val && req_rdy) |-> ##(data_width + 2) $rose(resp_val))
    else begin
      failures++;
      $error("resp_val did not rise data_width+2 cycles after acceptance");
    end

  // strobes quiet while reset is applied
  a_reset_quiet: assert property (@(posedge clk)
    reset |=> !(load || step || fix))
    else begin
      failures++;
      $error("datapath strobe active during reset");
    end

endmodule

bind imuldiv_top imuldiv_checker #(.data_width(data_width)) checker_i (
  .clk         (clk),
  .reset       (reset),
  .req_val     (req_val),
  .req_rdy     (req_rdy),
  .resp_val    (resp_val),
  .resp_rdy    (resp_rdy),
  .resp_result (resp_result),
  .load        (load),
  .step        (step),
  .fix         (fix)
);

/* testbench/imuldiv_tb.sv */
/*
 * testbench for the iterative multiply/divide unit
 * directed table, random phase against a reference model, handshake checks
 */

`timescale 1ns/10ps

module imuldiv_tb
  import imuldiv_pkg::*;
();

  localparam int data_width    = 32;
  localparam int ready_timeout = 100;
  localparam int resp_timeout  = 100;
  localparam int random_count  = 200;

  typedef logic [2*data_width-1:0] result_t;

  // one directed test where hold counts the cycles resp_rdy stays low
  typedef struct packed {
    imuldiv_op_e           op;
    logic [data_width-1:0] a;
    logic [data_width-1:0] b;
    logic [3:0]            hold;
    result_t               expected;
  } row_t;

  logic                  clk = 1'b0;
  logic                  reset;
  logic                  req_val;
  logic                  req_rdy;
  imuldiv_op_e           req_op;
  logic [data_width-1:0] req_a;
  logic [data_width-1:0] req_b;
  logic                  resp_val;
  logic                  resp_rdy;
  result_t               resp_result;

  row_t  rows[$];
  string row_names[$];
  int    value_errors    = 0;
  int    protocol_errors = 0;
  int    timeout_errors  = 0;

  imuldiv_top #(.data_width(data_width)) dut_i (
    .clk         (clk),
    .reset       (reset),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .req_op      (req_op),
    .req_a       (req_a),
    .req_b       (req_b),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy),
    .resp_result (resp_result)
  );

  // 40 ns period
  always #20 clk = ~clk;

  // ------------------------------
  // compare tasks and model
  // ------------------------------

  task automatic check_result(input string name, input result_t expected, input result_t actual);
    if (actual !== expected) begin
      value_errors++;
      $display("error: %s expected %h actual %h", name, expected, actual);
    end
  endtask

  task automatic check_latency(input string name, input int expected, input int actual);
    if (actual != expected) begin
      value_errors++;
      $display("error: %s latency expected %0d actual %0d", name, expected, actual);
    end
  endtask

  // full product or {remainder, quotient} with truncating division
  function automatic result_t model_result(input imuldiv_op_e op,
                                           input logic [data_width-1:0] a,
                                           input logic [data_width-1:0] b);
    logic signed [2*data_width-1:0] sa;
    logic signed [2*data_width-1:0] sb;
    logic [2*data_width-1:0]        ua;
    logic [2*data_width-1:0]        ub;
    logic [2*data_width-1:0]        q;
    logic [2*data_width-1:0]        r;
    sa = {{data_width{a[data_width-1]}}, a};
    sb = {{data_width{b[data_width-1]}}, b};
    ua = {{data_width{1'b0}}, a};
    ub = {{data_width{1'b0}}, b};
    // divide by zero gives an all-ones quotient and the dividend as remainder
    q = '1;
    r = ua;
    case (op)
      op_mul:  return sa * sb;
      op_mulu: return ua * ub;
      op_div: begin
        if (b != '0) begin
          q = sa / sb;
          r = sa % sb;
        end
      end
      default: begin
        if (b != '0) begin
          q = ua / ub;
          r = ua % ub;
        end
      end
    endcase
    return {r[data_width-1:0], q[data_width-1:0]};
  endfunction

  // ------------------------------
  // one request/response transaction
  // ------------------------------

  task automatic run_op(input string name, input imuldiv_op_e op,
                        input logic [data_width-1:0] a, input logic [data_width-1:0] b,
                        input int hold, input result_t expected);
    int      waited;
    int      cycles;
    int      i;
    logic    seen;
    result_t got;
    @(posedge clk);
    req_val <= 1'b1;
    req_op  <= op;
    req_a   <= a;
    req_b   <= b;
    waited = 0;
    @(negedge clk);
    while (!req_rdy && waited < ready_timeout) begin
      @(negedge clk);
      waited++;
    end
    if (!req_rdy) begin
      timeout_errors++;
      $display("%s: req_rdy never came high", name);
      return;
    end
    // accepting edge
    @(posedge clk);
    req_val <= 1'b0;
    // edges from acceptance up to the first one that samples resp_val high
    cycles = 0;
    seen   = 1'b0;
    got    = '0;
    while (!seen && cycles < resp_timeout) begin
      @(negedge clk);
      seen = resp_val;
      got  = resp_result;
      @(posedge clk);
      cycles++;
    end
    if (!seen) begin
      timeout_errors++;
      $display("%s: no response within %0d cycles", name, resp_timeout);
      return;
    end
    check_latency(name, data_width + 2, cycles);
    check_result(name, expected, got);
    // competing request while the response is held back
    if (hold > 0) begin
      req_val <= 1'b1;
      req_op  <= op_divu;
      req_a   <= ~a;
      req_b   <= ~b;
    end
    for (i = 0; i < hold; i++) begin
      @(negedge clk);
      if (!resp_val || req_rdy) begin
        protocol_errors++;
        $display("%s: response dropped or req_rdy rose under back-pressure", name);
      end
      check_result({name, " held"}, got, resp_result);
      @(posedge clk);
    end
    resp_rdy <= 1'b1;
    req_val  <= 1'b0;
    // response taken here
    @(posedge clk);
    resp_rdy <= 1'b0;
    @(negedge clk);
    if (resp_val || !req_rdy) begin
      protocol_errors++;
      $display("%s: unit did not return to idle after the response was taken", name);
    end
  endtask

  // ------------------------------
  // directed table
  // ------------------------------

  task automatic add_row(input string name, input imuldiv_op_e op,
                         input logic [data_width-1:0] a, input logic [data_width-1:0] b,
                         input int hold, input result_t expected);
    rows.push_back('{op, a, b, 4'(hold), expected});
    row_names.push_back(name);
  endtask

  task automatic load_table();
    add_row("mul_small",    op_mul,  32'd7,        32'd6,        0, 64'h00000000_0000002a);
    add_row("mul_neg_neg",  op_mul,  32'hfffffffd, 32'hfffffffb, 0, 64'h00000000_0000000f);
    add_row("mul_neg_pos",  op_mul,  32'hfffffffc, 32'd100,      2, 64'hffffffff_fffffe70);
    add_row("mul_min_min",  op_mul,  32'h80000000, 32'h80000000, 0, 64'h40000000_00000000);
    add_row("mulu_max",     op_mulu, 32'hffffffff, 32'hffffffff, 1, 64'hfffffffe_00000001);
    add_row("mulu_mixed",   op_mulu, 32'hfffffffc, 32'd2,        0, 64'h00000001_fffffff8);
    add_row("divu_basic",   op_divu, 32'd100,      32'd7,        0, 64'h00000002_0000000e);
    // remainder takes the dividend's sign
    add_row("div_neg_pos",  op_div,  32'hfffffff9, 32'd2,        4, 64'hffffffff_fffffffd);
    add_row("div_pos_neg",  op_div,  32'd7,        32'hfffffffe, 0, 64'h00000001_fffffffd);
    add_row("div_neg_neg",  op_div,  32'hfffffff9, 32'hfffffffe, 0, 64'hffffffff_00000003);
    add_row("divu_large",   op_divu, 32'hffffffff, 32'd10,       0, 64'h00000005_19999999);
    add_row("div_by_zero",  op_div,  32'hfffffffb, 32'd0,        0, 64'hfffffffb_ffffffff);
    add_row("divu_by_zero", op_divu, 32'h12345678, 32'd0,        3, 64'h12345678_ffffffff);
    add_row("div_min_neg1", op_div,  32'h80000000, 32'hffffffff, 0, 64'h00000000_80000000);
    add_row("mul_hold",     op_mul,  32'hfffffffe, 32'd3,        6, 64'hffffffff_fffffffa);
    add_row("divu_hold",    op_divu, 32'd1000,     32'd33,       3, 64'h0000000a_0000001e);
  endtask

  // ------------------------------
  // main sequence
  // ------------------------------

  initial begin
    int                    i;
    int                    hold;
    int                    assert_errors;
    imuldiv_op_e           op;
    logic [data_width-1:0] a;
    logic [data_width-1:0] b;
    logic [2:0]            sel;
    void'($urandom(32'h5b1f));
    reset    = 1'b1;
    req_val  = 1'b0;
    req_op   = op_mul;
    req_a    = '0;
    req_b    = '0;
    resp_rdy = 1'b0;
    load_table();
    repeat (4) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    if (!req_rdy || resp_val) begin
      protocol_errors++;
      $display("handshake outputs wrong after reset");
    end
    for (i = 0; i < rows.size() && timeout_errors == 0; i++) begin
      run_op(row_names[i], rows[i].op, rows[i].a, rows[i].b, rows[i].hold, rows[i].expected);
    end
    // random phase with divisors biased toward corner values
    for (i = 0; i < random_count && timeout_errors == 0; i++) begin
      op  = imuldiv_op_e'(2'($urandom_range(0, 3)));
      a   = $urandom;
      sel = 3'($urandom_range(0, 7));
      case (sel)
        3'd0:    b = '0;
        3'd1:    b = '1;
        3'd2:    b = $urandom_range(1, 16);
        default: b = $urandom;
      endcase
      hold = $urandom_range(0, 3);
      run_op($sformatf("random_%0d", i), op, a, b, hold, model_result(op, a, b));
    end
    assert_errors = dut_i.checker_i.failures;
    $display("value errors %0d, protocol errors %0d, timeouts %0d, assertion failures %0d",
             value_errors, protocol_errors, timeout_errors, assert_errors);
    if (value_errors + protocol_errors + timeout_errors + assert_errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

/* src.f */
rtl/imuldiv_pkg.sv
rtl/imuldiv_opnd_if.sv
rtl/imuldiv_ctrl.sv
rtl/imuldiv_sign.sv
rtl/imuldiv_mul_dpath.sv
rtl/imuldiv_div_dpath.sv
rtl/imuldiv_top.sv
testbench/imuldiv_checker.sv
testbench/imuldiv_tb.sv

/* Makefile */
# Verilator build and run for the multiply/divide unit

VERILATOR ?= verilator
TOP       ?= imuldiv_tb
FILE_LIST ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	grep -q "^Testbench passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
